// ==== design/aluIssuePkg.sv ====
`default_nettype none

package aluIssuePkg;

    // Data, pc and immediate all share one width.
    localparam int dataWidth = 32;

    // The branch and ALU groups each stay contiguous.
    typedef enum logic [4:0] {
        opLui,
        opAuipc,
        opJal,
        opJalr,
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu,
        opAddi,
        opSlti,
        opSltiu,
        opXori,
        opOri,
        opAndi,
        opSlli,
        opSrli,
        opSrai,
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd
    } aluOpT;

    typedef enum logic {
        notJump,
        jump
    } jumpT;

endpackage

`default_nettype wire

// ==== design/resStation.sv ====
`default_nettype none

module resStation #(
    parameter int nickWidth = 4,
    parameter int rsEntries = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rdy,
    input  logic                           dispatchEn,
    input  logic [aluIssuePkg::dataWidth-1:0] pc,
    input  logic [aluIssuePkg::dataWidth-1:0] imm,
    input  aluIssuePkg::aluOpT             op,
    input  logic [nickWidth-1:0]           rdNick,
    input  logic                           rs1Ready,
    input  logic [aluIssuePkg::dataWidth-1:0] rs1Val,
    input  logic [nickWidth-1:0]           rs1Nick,
    input  logic                           rs2Ready,
    input  logic [aluIssuePkg::dataWidth-1:0] rs2Val,
    input  logic [nickWidth-1:0]           rs2Nick,
    input  logic                           cdbValid,
    input  logic [nickWidth-1:0]           cdbNick,
    input  logic [aluIssuePkg::dataWidth-1:0] cdbData,
    output logic                           full,
    output logic                           issueEn,
    output logic [aluIssuePkg::dataWidth-1:0] issuePc,
    output aluIssuePkg::aluOpT             issueOp,
    output logic [aluIssuePkg::dataWidth-1:0] issueImm,
    output logic [nickWidth-1:0]           issueNick,
    output logic [aluIssuePkg::dataWidth-1:0] issueRs1,
    output logic [aluIssuePkg::dataWidth-1:0] issueRs2
);
    import aluIssuePkg::*;

    localparam int idxWidth = (rsEntries > 1) ? $clog2(rsEntries) : 1;
    localparam int cntWidth = $clog2(rsEntries + 1);

    typedef logic [idxWidth-1:0] idxT;
    typedef logic [cntWidth-1:0] cntT;

    logic [rsEntries-1:0] entValid;
    logic [dataWidth-1:0] entPc [rsEntries];
    aluOpT                entOp [rsEntries];
    logic [dataWidth-1:0] entImm [rsEntries];
    logic [nickWidth-1:0] entNick [rsEntries];
    logic [rsEntries-1:0] entRs1Rdy;
    logic [dataWidth-1:0] entRs1Val [rsEntries];
    logic [nickWidth-1:0] entRs1Nick [rsEntries];
    logic [rsEntries-1:0] entRs2Rdy;
    logic [dataWidth-1:0] entRs2Val [rsEntries];
    logic [nickWidth-1:0] entRs2Nick [rsEntries];
    // Number of valid entries that are older than this one.
    idxT                  entAge [rsEntries];

    logic [rsEntries-1:0] entReady;
    logic                 selFound;
    idxT                  selIdx;
    logic                 freeFound;
    idxT                  freeIdx;
    cntT                  validCount;
    idxT                  newAge;
    logic                 issueEnQ;

    assign full    = &entValid;
    assign issueEn = issueEnQ & rdy;

    always_comb begin
        selFound   = 1'b0;
        selIdx     = '0;
        freeFound  = 1'b0;
        freeIdx    = '0;
        validCount = '0;
        for (int i = 0; i < rsEntries; i++) begin
            entReady[i] = entValid[i] & entRs1Rdy[i] & entRs2Rdy[i];
            if (entValid[i]) begin
                validCount = validCount + 1'b1;
            end
            if (entReady[i] && (!selFound || entAge[i] < entAge[selIdx])) begin
                selFound = 1'b1;
                selIdx   = idxT'(i);
            end
            if (!entValid[i] && !freeFound) begin
                freeFound = 1'b1;
                freeIdx   = idxT'(i);
            end
        end
        // A new entry is younger than everything that survives this edge.
        newAge = idxT'(validCount - cntT'(selFound));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
            issueEnQ <= 1'b0;
        end else if (rdy) begin
            issueEnQ <= selFound;
            for (int i = 0; i < rsEntries; i++) begin
                if (selFound && selIdx == idxT'(i)) begin
                    entValid[i] <= 1'b0;
                end
            end
            if (dispatchEn && freeFound) begin
                entValid[freeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            for (int i = 0; i < rsEntries; i++) begin
                if (!entRs1Rdy[i] && cdbValid && cdbNick == entRs1Nick[i]) begin
                    entRs1Rdy[i] <= 1'b1;
                    entRs1Val[i] <= cdbData;
                end
                if (!entRs2Rdy[i] && cdbValid && cdbNick == entRs2Nick[i]) begin
                    entRs2Rdy[i] <= 1'b1;
                    entRs2Val[i] <= cdbData;
                end
                if (selFound && entValid[i] && entAge[i] > entAge[selIdx]) begin
                    entAge[i] <= entAge[i] - 1'b1;
                end
            end
            // A broadcast on the dispatch edge is caught here as well.
            if (dispatchEn && freeFound) begin
                entPc[freeIdx]      <= pc;
                entOp[freeIdx]      <= op;
                entImm[freeIdx]     <= imm;
                entNick[freeIdx]    <= rdNick;
                entRs1Rdy[freeIdx]  <= rs1Ready || (cdbValid && cdbNick == rs1Nick);
                entRs1Val[freeIdx]  <= rs1Ready ? rs1Val : cdbData;
                entRs1Nick[freeIdx] <= rs1Nick;
                entRs2Rdy[freeIdx]  <= rs2Ready || (cdbValid && cdbNick == rs2Nick);
                entRs2Val[freeIdx]  <= rs2Ready ? rs2Val : cdbData;
                entRs2Nick[freeIdx] <= rs2Nick;
                entAge[freeIdx]     <= newAge;
            end
            if (selFound) begin
                issuePc   <= entPc[selIdx];
                issueOp   <= entOp[selIdx];
                issueImm  <= entImm[selIdx];
                issueNick <= entNick[selIdx];
                issueRs1  <= entRs1Val[selIdx];
                issueRs2  <= entRs2Val[selIdx];
            end
        end
    end

    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst)
        dispatchEn && rdy |-> !full);

    // Operands that leave the station must already have been captured.
    issuedOperandsKnown: assert property (@(posedge clk) disable iff (rst)
        issueEn |-> !$isunknown(issueRs1) && !$isunknown(issueRs2));

    dispatchOpKnown: assert property (@(posedge clk) disable iff (rst)
        dispatchEn && rdy |-> !$isunknown(op) && op <= opAnd);

endmodule

`default_nettype wire

// ==== design/execUnit.sv ====
`default_nettype none

module execUnit #(
    parameter int nickWidth = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              issueEn,
    input  logic [aluIssuePkg::dataWidth-1:0] issuePc,
    input  aluIssuePkg::aluOpT                issueOp,
    input  logic [aluIssuePkg::dataWidth-1:0] issueImm,
    input  logic [nickWidth-1:0]              issueNick,
    input  logic [aluIssuePkg::dataWidth-1:0] issueRs1,
    input  logic [aluIssuePkg::dataWidth-1:0] issueRs2,
    output logic                              exValid,
    output logic [nickWidth-1:0]              exNick,
    output logic [aluIssuePkg::dataWidth-1:0] exData,
    output aluIssuePkg::jumpT                 exJump,
    output logic [aluIssuePkg::dataWidth-1:0] exNextPc
);
    import aluIssuePkg::*;

    logic                 exValidQ;
    logic [dataWidth-1:0] resData;
    jumpT                 resJump;
    logic [dataWidth-1:0] resNextPc;
    logic                 isBranch;
    logic                 taken;
    logic [dataWidth-1:0] jalrSum;

    assign exValid = exValidQ & rdy;

    always_comb begin
        resData   = '0;
        resJump   = notJump;
        resNextPc = issuePc + dataWidth'(4);
        isBranch  = 1'b0;
        taken     = 1'b0;
        jalrSum   = issueRs1 + issueImm;
        case (issueOp)
            opLui:   resData = issueImm;
            opAuipc: resData = issuePc + issueImm;
            opJal: begin
                resData   = issuePc + dataWidth'(4);
                resJump   = jump;
                resNextPc = issuePc + issueImm;
            end
            opJalr: begin
                resData   = issuePc + dataWidth'(4);
                resJump   = jump;
                resNextPc = {jalrSum[dataWidth-1:1], 1'b0};
            end
            opBeq: begin
                isBranch = 1'b1;
                taken    = issueRs1 == issueRs2;
            end
            opBne: begin
                isBranch = 1'b1;
                taken    = issueRs1 != issueRs2;
            end
            opBlt: begin
                isBranch = 1'b1;
                taken    = $signed(issueRs1) < $signed(issueRs2);
            end
            opBge: begin
                isBranch = 1'b1;
                taken    = $signed(issueRs1) >= $signed(issueRs2);
            end
            opBltu: begin
                isBranch = 1'b1;
                taken    = issueRs1 < issueRs2;
            end
            opBgeu: begin
                isBranch = 1'b1;
                taken    = issueRs1 >= issueRs2;
            end
            opAddi:  resData = issueRs1 + issueImm;
            opSlti:  resData = dataWidth'($signed(issueRs1) < $signed(issueImm));
            opSltiu: resData = dataWidth'(issueRs1 < issueImm);
            opXori:  resData = issueRs1 ^ issueImm;
            opOri:   resData = issueRs1 | issueImm;
            opAndi:  resData = issueRs1 & issueImm;
            opSlli:  resData = issueRs1 << issueImm[4:0];
            opSrli:  resData = issueRs1 >> issueImm[4:0];
            opSrai:  resData = $signed(issueRs1) >>> issueImm[4:0];
            opAdd:   resData = issueRs1 + issueRs2;
            opSub:   resData = issueRs1 - issueRs2;
            opSll:   resData = issueRs1 << issueRs2[4:0];
            opSlt:   resData = dataWidth'($signed(issueRs1) < $signed(issueRs2));
            opSltu:  resData = dataWidth'(issueRs1 < issueRs2);
            opXor:   resData = issueRs1 ^ issueRs2;
            opSrl:   resData = issueRs1 >> issueRs2[4:0];
            opSra:   resData = $signed(issueRs1) >>> issueRs2[4:0];
            opOr:    resData = issueRs1 | issueRs2;
            opAnd:   resData = issueRs1 & issueRs2;
            default: resData = '0;
        endcase
        // Branches leave data at zero and only redirect when taken.
        if (isBranch && taken) begin
            resJump   = jump;
            resNextPc = issuePc + issueImm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exValidQ <= 1'b0;
        end else if (rdy) begin
            exValidQ <= issueEn;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            exNick   <= issueNick;
            exData   <= resData;
            exJump   <= resJump;
            exNextPc <= resNextPc;
        end
    end

    // A freeze on the following edge only postpones the result.
    resultFollowsIssue: assert property (@(posedge clk) disable iff (rst)
        issueEn |=> !rdy || (exValid && exNick == $past(issueNick)));

endmodule

`default_nettype wire

// ==== design/aluIssueSlice.sv ====
`default_nettype none

module aluIssueSlice #(
    parameter int nickWidth = 4,
    parameter int rsEntries = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              dispatchEn,
    input  logic [aluIssuePkg::dataWidth-1:0] pc,
    input  aluIssuePkg::aluOpT                op,
    input  logic [aluIssuePkg::dataWidth-1:0] imm,
    input  logic [nickWidth-1:0]              rdNick,
    input  logic                              rs1Ready,
    input  logic [aluIssuePkg::dataWidth-1:0] rs1Val,
    input  logic [nickWidth-1:0]              rs1Nick,
    input  logic                              rs2Ready,
    input  logic [aluIssuePkg::dataWidth-1:0] rs2Val,
    input  logic [nickWidth-1:0]              rs2Nick,
    output logic                              full,
    output logic                              exValid,
    output logic [nickWidth-1:0]              exNick,
    output logic [aluIssuePkg::dataWidth-1:0] exData,
    output aluIssuePkg::jumpT                 exJump,
    output logic [aluIssuePkg::dataWidth-1:0] exNextPc
);
    import aluIssuePkg::*;

    logic                 issueEn;
    logic [dataWidth-1:0] issuePc;
    aluOpT                issueOp;
    logic [dataWidth-1:0] issueImm;
    logic [nickWidth-1:0] issueNick;
    logic [dataWidth-1:0] issueRs1;
    logic [dataWidth-1:0] issueRs2;

    // The execute result doubles as the wakeup bus for waiting entries.
    resStation #(
        .nickWidth(nickWidth),
        .rsEntries(rsEntries)
    ) rs (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .dispatchEn(dispatchEn),
        .pc(pc),
        .imm(imm),
        .op(op),
        .rdNick(rdNick),
        .rs1Ready(rs1Ready),
        .rs1Val(rs1Val),
        .rs1Nick(rs1Nick),
        .rs2Ready(rs2Ready),
        .rs2Val(rs2Val),
        .rs2Nick(rs2Nick),
        .cdbValid(exValid),
        .cdbNick(exNick),
        .cdbData(exData),
        .full(full),
        .issueEn(issueEn),
        .issuePc(issuePc),
        .issueOp(issueOp),
        .issueImm(issueImm),
        .issueNick(issueNick),
        .issueRs1(issueRs1),
        .issueRs2(issueRs2)
    );

    execUnit #(
        .nickWidth(nickWidth)
    ) ex (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .issueEn(issueEn),
        .issuePc(issuePc),
        .issueOp(issueOp),
        .issueImm(issueImm),
        .issueNick(issueNick),
        .issueRs1(issueRs1),
        .issueRs2(issueRs2),
        .exValid(exValid),
        .exNick(exNick),
        .exData(exData),
        .exJump(exJump),
        .exNextPc(exNextPc)
    );

endmodule

`default_nettype wire

// ==== sim/aluIssueSliceTb.sv ====
`default_nettype none

module aluIssueSliceTb;
    import aluIssuePkg::*;

    localparam int nickWidth = 4;
    localparam int rsEntries = 4;
    localparam int nickCount = 1 << nickWidth;

    logic                 clk;
    logic                 rst;
    logic                 rdy;
    logic                 dispatchEn;
    logic [dataWidth-1:0] pc;
    aluOpT                op;
    logic [dataWidth-1:0] imm;
    logic [nickWidth-1:0] rdNick;
    logic                 rs1Ready;
    logic [dataWidth-1:0] rs1Val;
    logic [nickWidth-1:0] rs1Nick;
    logic                 rs2Ready;
    logic [dataWidth-1:0] rs2Val;
    logic [nickWidth-1:0] rs2Nick;
    logic                 full;
    logic                 exValid;
    logic [nickWidth-1:0] exNick;
    logic [dataWidth-1:0] exData;
    jumpT                 exJump;
    logic [dataWidth-1:0] exNextPc;

    // Scoreboard indexed by nick.
    logic                 inFlight [nickCount];
    logic [dataWidth-1:0] expData [nickCount];
    logic                 expJump [nickCount];
    logic [dataWidth-1:0] expNext [nickCount];

    integer               seed = 25643;
    int                   errors = 0;
    int                   testsRun = 0;
    int                   dispatched = 0;
    int                   outstanding = 0;
    int                   cycles = 0;
    logic [nickWidth-1:0] nextNick = '0;
    logic                 sawFull = 1'b0;

    aluIssueSlice #(
        .nickWidth(nickWidth),
        .rsEntries(rsEntries)
    ) dut (
        .clk(clk), .rst(rst), .rdy(rdy), .dispatchEn(dispatchEn),
        .pc(pc), .op(op), .imm(imm), .rdNick(rdNick),
        .rs1Ready(rs1Ready), .rs1Val(rs1Val), .rs1Nick(rs1Nick),
        .rs2Ready(rs2Ready), .rs2Val(rs2Val), .rs2Nick(rs2Nick),
        .full(full), .exValid(exValid), .exNick(exNick), .exData(exData),
        .exJump(exJump), .exNextPc(exNextPc)
    );

    always #10 clk = ~clk;

    function automatic logic [dataWidth-1:0] rnd();
        rnd = $random(seed);
    endfunction

    // Returns {data, jump, next pc} for one instruction.
    function automatic logic [2*dataWidth:0] expectResult(input aluOpT o,
            input logic [dataWidth-1:0] p,
            input logic [dataWidth-1:0] i,
            input logic [dataWidth-1:0] a,
            input logic [dataWidth-1:0] b);
        logic [dataWidth-1:0] d;
        logic                 j;
        logic [dataWidth-1:0] n;
        logic                 t;
        d = '0;
        j = 1'b0;
        n = p + 4;
        t = 1'b0;
        case (o)
            opLui:   d = i;
            opAuipc: d = p + i;
            opJal: begin
                d = p + 4;
                j = 1'b1;
                n = p + i;
            end
            opJalr: begin
                d = p + 4;
                j = 1'b1;
                n = (a + i) & ~32'd1;
            end
            opBeq:   t = (a == b);
            opBne:   t = (a != b);
            opBlt:   t = ($signed(a) < $signed(b));
            opBge:   t = !($signed(a) < $signed(b));
            opBltu:  t = (a < b);
            opBgeu:  t = !(a < b);
            opAddi:  d = a + i;
            opSlti:  d = {31'd0, $signed(a) < $signed(i)};
            opSltiu: d = {31'd0, a < i};
            opXori:  d = a ^ i;
            opOri:   d = a | i;
            opAndi:  d = a & i;
            opSlli:  d = a << i[4:0];
            opSrli:  d = a >> i[4:0];
            opSrai:  d = $unsigned($signed(a) >>> i[4:0]);
            opAdd:   d = a + b;
            opSub:   d = a - b;
            opSll:   d = a << b[4:0];
            opSlt:   d = {31'd0, $signed(a) < $signed(b)};
            opSltu:  d = {31'd0, a < b};
            opXor:   d = a ^ b;
            opSrl:   d = a >> b[4:0];
            opSra:   d = $unsigned($signed(a) >>> b[4:0]);
            opOr:    d = a | b;
            opAnd:   d = a & b;
            default: d = '0;
        endcase
        if (t) begin
            j = 1'b1;
            n = p + i;
        end
        return {d, j, n};
    endfunction

    // A dependent source waits on its producer only while that result is still due.
    task automatic dispatchOp(input aluOpT o,
            input logic [dataWidth-1:0] p,
            input logic [dataWidth-1:0] i,
            input logic dep1,
            input logic [dataWidth-1:0] v1,
            input logic [nickWidth-1:0] prod1,
            input logic dep2,
            input logic [dataWidth-1:0] v2,
            input logic [nickWidth-1:0] prod2,
            output logic [nickWidth-1:0] nick);
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [2*dataWidth:0] res;
        @(negedge clk);
        while (full || !rdy) begin
            @(negedge clk);
        end
        while (inFlight[nextNick]) begin
            nextNick = nextNick + 1'b1;
        end
        nick = nextNick;
        nextNick = nextNick + 1'b1;
        a = dep1 ? expData[prod1] : v1;
        b = dep2 ? expData[prod2] : v2;
        res = expectResult(o, p, i, a, b);
        expData[nick] = res[2*dataWidth:dataWidth+1];
        expJump[nick] = res[dataWidth];
        expNext[nick] = res[dataWidth-1:0];
        @(posedge clk);
        dispatchEn <= 1'b1;
        op         <= o;
        pc         <= p;
        imm        <= i;
        rdNick     <= nick;
        rs1Ready   <= !(dep1 && inFlight[prod1]);
        rs1Val     <= a;
        rs1Nick    <= dep1 ? prod1 : '0;
        rs2Ready   <= !(dep2 && inFlight[prod2]);
        rs2Val     <= b;
        rs2Nick    <= dep2 ? prod2 : '0;
        inFlight[nick] = 1'b1;
        outstanding++;
        dispatched++;
        @(posedge clk);
        dispatchEn <= 1'b0;
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic drain();
        while (outstanding != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        $display("Test %0d %s: %0d errors", testsRun, name, errors - errBefore);
    endtask

    always @(negedge clk) begin
        if (!rst && exValid) begin
            assert (inFlight[exNick]) else begin
                $display("Result for nick %0d arrived with no instruction waiting for it",
                         exNick);
                errors++;
            end
            assert (exData == expData[exNick] && exJump == jumpT'(expJump[exNick])
                    && exNextPc == expNext[exNick]) else begin
                $display("FAILED at %0t: nick %0d got %h/%0d/%h, expected %h/%0d/%h",
                         $time, exNick, exData, exJump, exNextPc,
                         expData[exNick], expJump[exNick], expNext[exNick]);
                errors++;
            end
            if (inFlight[exNick]) begin
                inFlight[exNick] = 1'b0;
                outstanding--;
            end
        end
        if (full) begin
            sawFull = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * dispatched + 200) begin
            $display("Timeout after %0d cycles, results never arrived", cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [nickWidth-1:0]  n0;
        logic [nickWidth-1:0]  n1;
        logic [nickWidth-1:0]  n2;
        logic [dataWidth-1:0]  bounds [4];
        aluOpT                 cmpOps [10];
        int                    errBefore;
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        dispatchEn = 1'b0;
        pc = '0;
        op = opLui;
        imm = '0;
        rdNick = '0;
        rs1Ready = 1'b0;
        rs1Val = '0;
        rs1Nick = '0;
        rs2Ready = 1'b0;
        rs2Val = '0;
        rs2Nick = '0;
        for (int k = 0; k < nickCount; k++) begin
            inFlight[k] = 1'b0;
        end
        bounds = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000};
        cmpOps = '{opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
                   opSlt, opSltu, opSlti, opSltiu};
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        errBefore = errors;
        @(negedge clk);
        assert (!exValid && !full) else begin
            $display("FAILED at %0t: exValid or full high after reset", $time);
            errors++;
        end
        reportTest("reset", errBefore);

        errBefore = errors;
        for (int k = 0; k <= int'(opAnd); k++) begin
            repeat (2) dispatchOp(aluOpT'(k), rnd() & ~32'd3, rnd() & ~32'd1,
                                  1'b0, rnd(), '0, 1'b0, rnd(), '0, n0);
        end
        foreach (cmpOps[c]) begin
            foreach (bounds[x]) begin
                foreach (bounds[y]) begin
                    dispatchOp(cmpOps[c], rnd() & ~32'd3, bounds[y],
                               1'b0, bounds[x], '0, 1'b0, bounds[y], '0, n0);
                end
            end
        end
        drain();
        reportTest("opcodes", errBefore);

        errBefore = errors;
        dispatchOp(opAddi, 32'h100, rnd(), 1'b0, rnd(), '0, 1'b0, '0, '0, n0);
        dispatchOp(opAdd, 32'h104, '0, 1'b1, '0, n0, 1'b0, rnd(), '0, n1);
        dispatchOp(opSub, 32'h108, '0, 1'b1, '0, n1, 1'b1, '0, n0, n2);
        dispatchOp(opBne, 32'h10c, 32'h40, 1'b1, '0, n2, 1'b1, '0, n1, n1);
        // The consumer below lands on the edge its producer broadcasts.
        dispatchOp(opLui, 32'h110, rnd(), 1'b0, '0, '0, 1'b0, '0, '0, n0);
        waitCycles(1);
        dispatchOp(opXor, 32'h114, '0, 1'b1, '0, n0, 1'b0, rnd(), '0, n1);
        dispatchOp(opJalr, 32'h118, 32'h7, 1'b1, '0, n1, 1'b0, '0, '0, n2);
        dispatchOp(opOr, 32'h11c, '0, 1'b0, rnd(), '0, 1'b0, rnd(), '0, n0);
        drain();
        reportTest("dependencies", errBefore);

        errBefore = errors;
        sawFull = 1'b0;
        dispatchOp(opAuipc, 32'h200, rnd(), 1'b0, '0, '0, 1'b0, '0, '0, n0);
        for (int k = 0; k < 16; k++) begin
            dispatchOp(opAdd, 32'h204, '0, 1'b1, '0, n0, 1'b0, rnd(), '0, n0);
        end
        drain();
        assert (sawFull) else begin
            $display("The full flag never went high during the dependency chain");
            errors++;
        end
        reportTest("back-pressure", errBefore);

        errBefore = errors;
        dispatchOp(opSra, 32'h300, '0, 1'b0, rnd(), '0, 1'b0, rnd(), '0, n0);
        dispatchOp(opSll, 32'h304, '0, 1'b1, '0, n0, 1'b0, rnd(), '0, n1);
        dispatchOp(opBge, 32'h308, 32'h10, 1'b1, '0, n1, 1'b1, '0, n0, n2);
        rdy <= 1'b0;
        repeat (6) begin
            @(negedge clk);
            assert (!exValid) else begin
                $display("FAILED at %0t: result appeared while frozen", $time);
                errors++;
            end
        end
        @(posedge clk);
        rdy <= 1'b1;
        drain();
        reportTest("freeze", errBefore);

        $display("%0d tests, %0d instructions, %0d errors", testsRun, dispatched, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== aluIssueSlice.f ====
design/aluIssuePkg.sv
design/resStation.sv
design/execUnit.sv
design/aluIssueSlice.sv
sim/aluIssueSliceTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module aluIssueSliceTb -f aluIssueSlice.f -o aluIssueSliceSim

output=$(./obj_dir/aluIssueSliceSim)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
